//--- common/raster_pkg.sv
// Geometry types shared by the line engine, imported wherever coordinates or pixels are used
package raster_pkg;

	// One screen coordinate, unsigned
	typedef logic [15:0] coord_t;

	// Bresenham error term
	// Two extra bits so twice a full 16-bit difference still fits signed
	typedef logic signed [17:0] err_t;

	// Line command as sampled on calculate
	typedef struct packed {
		coord_t x1;
		coord_t y1;
		coord_t x2;
		coord_t y2;
	} line_cmd_t;

	// One pixel position, x in the upper half
	typedef struct packed {
		coord_t x;
		coord_t y;
	} pixel_t;

endpackage

//--- common/engine_pkg.sv
// Control types for the line engine, imported by the stepper and used for default widths
package engine_pkg;

	// Stepper FSM states
	// Idle until a line is loaded
	// Run while pixels are handed out
	// Last holds for the single cycle that ends the line
	typedef enum logic [1:0] {
		STEP_IDLE,
		STEP_RUN,
		STEP_LAST
	} step_state_t;

	// Step counter width unless the top level overrides it
	// Wide enough for the longest line on a 16-bit coordinate grid
	parameter int CNT_BITS_DEFAULT = 16;

endpackage

//--- verilog/flex_counter.sv
// Generic up counter with clear, enable and a flag raised when the rollover value is reached
`timescale 1ns/100ps

module flex_counter
#(
	parameter int NUM_CNT_BITS = engine_pkg::CNT_BITS_DEFAULT
)
(
	input  logic                    clk,
	input  logic                    reset,
	input  logic                    clear,
	input  logic                    count_enable,
	input  logic [NUM_CNT_BITS-1:0] rollover_val,
	output logic [NUM_CNT_BITS-1:0] count_out,
	output logic                    rollover_flag
);
	logic [NUM_CNT_BITS-1:0] next_count;

	// Clear takes priority over enable
	// Wraps to zero after reaching the rollover value
	always_comb
	begin
		next_count = count_out;
		if (clear)
			next_count = '0;
		else if (count_enable)
		begin
			if (count_out == rollover_val)
				next_count = '0;
			else
				next_count = count_out + NUM_CNT_BITS'(1);
		end
	end

	always_ff @(posedge clk, negedge reset)
	begin
		if (!reset)
		begin
			count_out <= '0;
			rollover_flag <= 1'b0;
		end
		else
		begin
			count_out <= next_count;
			// Compared against the new count so a zero rollover flags right at clear
			rollover_flag <= (next_count == rollover_val);
		end
	end

endmodule

//--- draw_line/line_setup.sv
// Line setup stage of draw_line, latching a command and deriving deltas, directions and length
`timescale 1ns/100ps

module line_setup
(
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  calculate,
	input  raster_pkg::line_cmd_t cmd,
	output raster_pkg::pixel_t    start,
	output raster_pkg::coord_t    dx,
	output raster_pkg::coord_t    dy,
	output logic                  sx,
	output logic                  sy,
	output raster_pkg::coord_t    length,
	output logic                  load
);
	import raster_pkg::*;

	coord_t abs_dx;
	coord_t abs_dy;
	logic   dir_x;
	logic   dir_y;

	// Absolute differences and step directions
	// A direction bit high means stepping towards larger coordinates
	always_comb
	begin
		if (cmd.x2 >= cmd.x1)
		begin
			abs_dx = cmd.x2 - cmd.x1;
			dir_x = 1'b1;
		end
		else
		begin
			abs_dx = cmd.x1 - cmd.x2;
			dir_x = 1'b0;
		end
		if (cmd.y2 >= cmd.y1)
		begin
			abs_dy = cmd.y2 - cmd.y1;
			dir_y = 1'b1;
		end
		else
		begin
			abs_dy = cmd.y1 - cmd.y2;
			dir_y = 1'b0;
		end
	end

	// Geometry captured on calculate, only read after load
	always_ff @(posedge clk)
	begin
		if (calculate)
		begin
			start <= '{x: cmd.x1, y: cmd.y1};
			dx <= abs_dx;
			dy <= abs_dy;
			sx <= dir_x;
			sy <= dir_y;
			// Major axis sets the number of steps
			length <= (abs_dx > abs_dy) ? abs_dx : abs_dy;
		end
	end

	// Load follows calculate by one cycle, once the registers above are settled
	always_ff @(posedge clk, negedge reset)
	begin
		if (!reset)
			load <= 1'b0;
		else
			load <= calculate;
	end

endmodule

//--- draw_line/line_stepper.sv
// Bresenham stepper of draw_line, moving one pixel along the loaded line per get_pixel
`timescale 1ns/100ps

module line_stepper
(
	input  logic               clk,
	input  logic               reset,
	input  logic               load,
	input  raster_pkg::pixel_t start,
	input  raster_pkg::coord_t dx,
	input  raster_pkg::coord_t dy,
	input  logic               sx,
	input  logic               sy,
	input  logic               get_pixel,
	input  logic               last,
	output raster_pkg::pixel_t cur_pixel,
	output logic               advance,
	output logic               busy,
	output logic               line_done,
	output logic               step_valid
);
	import raster_pkg::*;
	import engine_pkg::*;

	step_state_t state;
	step_state_t next_state;
	err_t        err;
	err_t        err_next;
	err_t        e2;
	err_t        dx_e;
	err_t        dy_e;
	logic        step_x;
	logic        step_y;
	coord_t      x_next;
	coord_t      y_next;

	// Step only when running and the counter has not flagged the final pixel
	// A reload wins over any pending get_pixel
	assign advance = get_pixel && (state == STEP_RUN) && !last && !load;

	// Moore outputs straight from the state register
	assign busy = (state == STEP_RUN);
	assign line_done = (state == STEP_LAST);

	// Error arithmetic, deltas zero extended into the signed term
	assign dx_e = {2'b00, dx};
	assign dy_e = {2'b00, dy};
	assign e2 = err <<< 1;
	assign step_x = (e2 > -dy_e);
	assign step_y = (e2 < dx_e);

	always_comb
	begin
		err_next = err;
		x_next = cur_pixel.x;
		y_next = cur_pixel.y;
		if (step_x)
		begin
			err_next = err_next - dy_e;
			x_next = sx ? cur_pixel.x + 16'd1 : cur_pixel.x - 16'd1;
		end
		if (step_y)
		begin
			err_next = err_next + dx_e;
			y_next = sy ? cur_pixel.y + 16'd1 : cur_pixel.y - 16'd1;
		end
	end

	// Line lifecycle
	always_comb
	begin
		next_state = state;
		if (load)
			next_state = STEP_RUN;
		else
		begin
			case (state)
				STEP_RUN:
					if (last)
						next_state = STEP_LAST;
				STEP_LAST:
					next_state = STEP_IDLE;
				default:
					next_state = STEP_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk, negedge reset)
	begin
		if (!reset)
		begin
			state <= STEP_IDLE;
			step_valid <= 1'b0;
		end
		else
		begin
			state <= next_state;
			// One pulse for the start pixel and one per taken step
			step_valid <= load || advance;
		end
	end

	// Current pixel and error term
	always_ff @(posedge clk)
	begin
		if (load)
		begin
			cur_pixel <= start;
			err <= dx_e - dy_e;
		end
		else if (advance)
		begin
			cur_pixel <= '{x: x_next, y: y_next};
			err <= err_next;
		end
	end

endmodule

//--- draw_line/draw_line.sv
// Line drawing block, stepping a commanded line one pixel per get_pixel strobe
`timescale 1ns/100ps

module draw_line
#(
	parameter int CNT_BITS = engine_pkg::CNT_BITS_DEFAULT
)
(
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  calculate,
	input  raster_pkg::line_cmd_t cmd,
	input  logic                  get_pixel,
	output logic                  busy,
	output logic                  line_done,
	output raster_pkg::pixel_t    cur_pixel,
	output logic                  step_valid,
	output logic                  new_line
);
	import raster_pkg::*;

	pixel_t start;
	coord_t dx;
	coord_t dy;
	logic   sx;
	logic   sy;
	coord_t length;
	logic   load;
	logic   advance;
	logic   last;

	// Endpoint capture and delta math
	line_setup setup_inst (
		.clk      (clk),
		.reset    (reset),
		.calculate(calculate),
		.cmd      (cmd),
		.start    (start),
		.dx       (dx),
		.dy       (dy),
		.sx       (sx),
		.sy       (sy),
		.length   (length),
		.load     (load)
	);

	// Error accumulator and pixel position
	line_stepper stepper_inst (
		.clk       (clk),
		.reset     (reset),
		.load      (load),
		.start     (start),
		.dx        (dx),
		.dy        (dy),
		.sx        (sx),
		.sy        (sy),
		.get_pixel (get_pixel),
		.last      (last),
		.cur_pixel (cur_pixel),
		.advance   (advance),
		.busy      (busy),
		.line_done (line_done),
		.step_valid(step_valid)
	);

	// Step counter, cleared at load so the flag sees the new length
	// Rollover marks the final pixel of the line
	flex_counter #(
		.NUM_CNT_BITS(CNT_BITS)
	) step_counter_inst (
		.clk          (clk),
		.reset        (reset),
		.clear        (load),
		.count_enable (advance),
		.rollover_val (CNT_BITS'(length)),
		.count_out    (),
		.rollover_flag(last)
	);

	// Lines up with the start pixel's step_valid pulse
	always_ff @(posedge clk, negedge reset)
	begin
		if (!reset)
			new_line <= 1'b0;
		else
			new_line <= load;
	end

endmodule

//--- verilog/screen_clip.sv
// Screen clip stage, passing on-screen pixels from the stepper and counting those accepted
`timescale 1ns/100ps

module screen_clip
#(
	parameter int SCREEN_W = 640,
	parameter int SCREEN_H = 480
)
(
	input  logic               clk,
	input  logic               reset,
	input  logic               new_line,
	input  raster_pkg::pixel_t cur_pixel,
	input  logic               step_valid,
	output raster_pkg::pixel_t pixel,
	output logic               pixel_valid,
	output raster_pkg::coord_t pixel_count
);
	import raster_pkg::*;

	logic on_screen;
	logic accept;

	// Unsigned coordinates, so only the upper bounds matter
	assign on_screen = (cur_pixel.x < coord_t'(SCREEN_W)) && (cur_pixel.y < coord_t'(SCREEN_H));
	assign accept = step_valid && on_screen;

	// Pixel payload
	always_ff @(posedge clk)
	begin
		if (step_valid)
			pixel <= cur_pixel;
	end

	always_ff @(posedge clk, negedge reset)
	begin
		if (!reset)
		begin
			pixel_valid <= 1'b0;
			pixel_count <= '0;
		end
		else
		begin
			pixel_valid <= accept;
			// Start pixel arrives with new_line and opens the count
			if (new_line)
				pixel_count <= accept ? 16'd1 : 16'd0;
			else if (accept)
				pixel_count <= pixel_count + 16'd1;
		end
	end

endmodule

//--- verilog/line_engine_top.sv
// Line engine top level, joining the line stepper to the screen clip and fixing their sizes
`timescale 1ns/100ps

module line_engine_top
#(
	parameter int CNT_BITS = engine_pkg::CNT_BITS_DEFAULT,
	parameter int SCREEN_W = 640,
	parameter int SCREEN_H = 480
)
(
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  calculate,
	input  raster_pkg::line_cmd_t cmd,
	input  logic                  get_pixel,
	output logic                  busy,
	output logic                  line_done,
	output raster_pkg::pixel_t    pixel,
	output logic                  pixel_valid,
	output raster_pkg::coord_t    pixel_count
);
	import raster_pkg::*;

	pixel_t cur_pixel;
	logic   step_valid;
	logic   new_line;

	// Pixel stepping
	draw_line #(
		.CNT_BITS(CNT_BITS)
	) draw_line_inst (
		.clk       (clk),
		.reset     (reset),
		.calculate (calculate),
		.cmd       (cmd),
		.get_pixel (get_pixel),
		.busy      (busy),
		.line_done (line_done),
		.cur_pixel (cur_pixel),
		.step_valid(step_valid),
		.new_line  (new_line)
	);

	// Screen bounds check and accepted pixel count
	screen_clip #(
		.SCREEN_W(SCREEN_W),
		.SCREEN_H(SCREEN_H)
	) screen_clip_inst (
		.clk        (clk),
		.reset      (reset),
		.new_line   (new_line),
		.cur_pixel  (cur_pixel),
		.step_valid (step_valid),
		.pixel      (pixel),
		.pixel_valid(pixel_valid),
		.pixel_count(pixel_count)
	);

endmodule

//--- testbench/line_engine_checker.sv
// Protocol assertions for draw_line, attached to each draw_line instance through bind
`timescale 1ns/100ps

module line_engine_checker
(
	input logic clk,
	input logic reset,
	input logic busy,
	input logic line_done,
	input logic step_valid
);
	// Failed assertions, read back by the testbench summary
	int fail_count = 0;

	// End of line is a single-cycle pulse
	done_one_cycle: assert property (@(posedge clk) disable iff (!reset)
		line_done |=> !line_done)
	else
	begin
		$error("line_done held high for more than one cycle");
		fail_count++;
	end

	// A line only ends through the final step
	busy_falls_with_done: assert property (@(posedge clk) disable iff (!reset)
		$fell(busy) |-> line_done)
	else
	begin
		$error("busy fell without a line_done pulse");
		fail_count++;
	end

	// Pixels only come out of a running line
	no_step_when_idle: assert property (@(posedge clk) disable iff (!reset)
		step_valid |-> busy)
	else
	begin
		$error("step_valid pulsed while the stepper was idle");
		fail_count++;
	end

endmodule

// One checker per draw_line instance
bind draw_line line_engine_checker checker_inst (
	.clk       (clk),
	.reset     (reset),
	.busy      (busy),
	.line_done (line_done),
	.step_valid(step_valid)
);

//--- testbench/line_engine_tb.sv
// Directed testbench for the line engine that the Verilator Makefile builds and runs
`timescale 1ns/100ps

module line_engine_tb;
	import raster_pkg::*;

	localparam int SCREEN_W = 640;
	localparam int SCREEN_H = 480;
	// Upper bound on cycles or strobes for any single wait
	localparam int WAIT_LIMIT = 5000;

	logic      clk;
	logic      reset;
	logic      calculate;
	line_cmd_t cmd;
	logic      get_pixel;
	logic      busy;
	logic      line_done;
	pixel_t    pixel;
	logic      pixel_valid;
	coord_t    pixel_count;

	// Filled only by the monitor and read by tests from a recorded base
	pixel_t got_q[$];
	int     done_count = 0;

	int errors;
	int tests_run;
	int tests_failed;
	int assert_fails;

	line_engine_top #(
		.CNT_BITS(16),
		.SCREEN_W(SCREEN_W),
		.SCREEN_H(SCREEN_H)
	) line_engine_inst (
		.clk        (clk),
		.reset      (reset),
		.calculate  (calculate),
		.cmd        (cmd),
		.get_pixel  (get_pixel),
		.busy       (busy),
		.line_done  (line_done),
		.pixel      (pixel),
		.pixel_valid(pixel_valid),
		.pixel_count(pixel_count)
	);

	// 100 ns clock
	always #50 clk = ~clk;

	// Registered outputs sampled mid-cycle
	always @(negedge clk)
	begin
		if (pixel_valid)
			got_q.push_back(pixel);
		if (line_done)
			done_count++;
	end

	task automatic abort_on_timeout(input string what);
		$display("ERROR: timed out waiting for %s", what);
		$display("Simulation finished: FAIL");
		$finish;
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] expected, inout bit ok);
		assert (got == expected)
		else
		begin
			$display("FAIL %s: got %h, expected %h", name, got, expected);
			errors++;
			ok = 1'b0;
		end
	endtask

	function automatic line_cmd_t make_cmd(input int x1, input int y1, input int x2, input int y2);
		line_cmd_t c;
		c.x1 = coord_t'(x1);
		c.y1 = coord_t'(y1);
		c.x2 = coord_t'(x2);
		c.y2 = coord_t'(y2);
		return c;
	endfunction

	// Either close to zero or close to the screen edge
	function automatic int near_bound(input int bound);
		if ($urandom_range(1, 0) == 1)
			return $urandom_range(40, 0);
		return $urandom_range(bound + 40, bound - 40);
	endfunction

	// Called on a falling edge and returns once busy is seen high
	task automatic start_line(input line_cmd_t c);
		int guard;
		guard = 0;
		cmd = c;
		calculate = 1'b1;
		@(negedge clk);
		calculate = 1'b0;
		while (!busy && guard < WAIT_LIMIT)
		begin
			@(negedge clk);
			guard++;
		end
		if (!busy)
			abort_on_timeout("busy after calculate");
	endtask

	// Strobe get_pixel with random gaps until the line ends or max_steps strobes are out
	task automatic step_pixels(input int max_steps, input int max_gap);
		int strobes;
		int gap;
		strobes = 0;
		while (busy && strobes < max_steps)
		begin
			gap = (max_gap > 0) ? $urandom_range(max_gap, 0) : 0;
			repeat (gap) @(negedge clk);
			get_pixel = 1'b1;
			@(negedge clk);
			get_pixel = 1'b0;
			strobes++;
		end
		if (busy && max_steps >= WAIT_LIMIT)
			abort_on_timeout("line_done at the end of a line");
	endtask

	// Draw one line and compare it with the stepping rule and the screen filter
	task automatic check_line(input line_cmd_t c, input int max_gap, inout bit ok);
		pixel_t exp_q[$];
		pixel_t p;
		int     x;
		int     y;
		int     x2;
		int     y2;
		int     dx;
		int     dy;
		int     sx;
		int     sy;
		int     err;
		int     e2;
		int     len;
		int     i;
		int     base;
		int     done_base;
		x = int'(c.x1);
		y = int'(c.y1);
		x2 = int'(c.x2);
		y2 = int'(c.y2);
		dx = (x2 >= x) ? x2 - x : x - x2;
		dy = (y2 >= y) ? y2 - y : y - y2;
		sx = (x2 >= x) ? 1 : -1;
		sy = (y2 >= y) ? 1 : -1;
		err = dx - dy;
		len = (dx > dy) ? dx : dy;
		// Model walks length plus one pixels and keeps the on-screen ones
		for (i = 0; i <= len; i++)
		begin
			if (x < SCREEN_W && y < SCREEN_H)
			begin
				p.x = coord_t'(x);
				p.y = coord_t'(y);
				exp_q.push_back(p);
			end
			e2 = 2 * err;
			if (e2 > -dy)
			begin
				err = err - dy;
				x = x + sx;
			end
			if (e2 < dx)
			begin
				err = err + dx;
				y = y + sy;
			end
		end
		base = got_q.size();
		done_base = done_count;
		start_line(c);
		step_pixels(WAIT_LIMIT, max_gap);
		// Final pixel and line_done land with busy falling
		repeat (2) @(negedge clk);
		check_value("pixel_valid pulses", got_q.size() - base, exp_q.size(), ok);
		for (i = 0; i < exp_q.size() && base + i < got_q.size(); i++)
			check_value($sformatf("pixel[%0d]", i), got_q[base + i], exp_q[i], ok);
		check_value("pixel_count", 32'(pixel_count), exp_q.size(), ok);
		check_value("line_done pulses", done_count - done_base, 1, ok);
		check_value("busy", 32'(busy), 0, ok);
		// Endpoint taken straight from the command
		if (x2 < SCREEN_W && y2 < SCREEN_H && got_q.size() > base)
			check_value("last pixel", got_q[got_q.size() - 1], {c.x2, c.y2}, ok);
	endtask

	task automatic report_test(input string name, input bit ok);
		tests_run++;
		if (!ok)
			tests_failed++;
		$display("Test %s: %s", name, ok ? "passed" : "failed");
	endtask

	task automatic test_axis_lines();
		bit ok;
		ok = 1'b1;
		check_line(make_cmd(100, 200, 140, 200), 0, ok);
		check_line(make_cmd(140, 210, 100, 210), 0, ok);
		check_line(make_cmd(120, 50, 120, 90), 0, ok);
		check_line(make_cmd(130, 90, 130, 50), 0, ok);
		report_test("axis_lines", ok);
	endtask

	task automatic test_octants();
		bit ok;
		int ox[10];
		int oy[10];
		int i;
		ok = 1'b1;
		// Shallow and steep in each quadrant and then two pure diagonals
		ox = '{40, 15, -15, -40, -40, -15, 15, 40, 25, -25};
		oy = '{15, 40, 40, 15, -15, -40, -40, -15, 25, -25};
		for (i = 0; i < 10; i++)
			check_line(make_cmd(300, 240, 300 + ox[i], 240 + oy[i]), 0, ok);
		report_test("octants", ok);
	endtask

	task automatic test_zero_length();
		bit ok;
		ok = 1'b1;
		check_line(make_cmd(50, 60, 50, 60), 0, ok);
		report_test("zero_length", ok);
	endtask

	task automatic test_clipping();
		bit ok;
		ok = 1'b1;
		check_line(make_cmd(600, 440, 700, 500), 0, ok);
		check_line(make_cmd(10, 470, 40, 495), 0, ok);
		check_line(make_cmd(700, 100, 600, 120), 0, ok);
		// Entirely off screen so nothing is accepted
		check_line(make_cmd(650, 490, 660, 500), 0, ok);
		report_test("clipping", ok);
	endtask

	task automatic test_gaps_restart();
		bit ok;
		int base;
		int exp_count;
		ok = 1'b1;
		check_line(make_cmd(20, 30, 90, 55), 4, ok);
		// Previous line lies fully on screen with x as its major axis
		exp_count = 90 - 20 + 1;
		// Strobes while idle
		base = got_q.size();
		repeat (4)
		begin
			get_pixel = 1'b1;
			@(negedge clk);
			get_pixel = 1'b0;
			@(negedge clk);
		end
		repeat (2) @(negedge clk);
		check_value("pixel_valid pulses while idle", got_q.size() - base, 0, ok);
		check_value("pixel_count", 32'(pixel_count), exp_count, ok);
		// Abandon a line partway and restart with a new command
		start_line(make_cmd(400, 100, 300, 180));
		step_pixels(5, 1);
		repeat (3) @(negedge clk);
		check_line(make_cmd(200, 300, 260, 250), 2, ok);
		report_test("gaps_restart", ok);
	endtask

	task automatic test_random_lines();
		bit        ok;
		int        i;
		line_cmd_t c;
		ok = 1'b1;
		for (i = 0; i < 20; i++)
		begin
			c = make_cmd(near_bound(SCREEN_W), near_bound(SCREEN_H),
				near_bound(SCREEN_W), near_bound(SCREEN_H));
			check_line(c, 2, ok);
		end
		report_test("random_lines", ok);
	endtask

	initial
	begin
		void'($urandom(32'hb92e_da45));
		clk = 1'b0;
		reset = 1'b0;
		calculate = 1'b0;
		get_pixel = 1'b0;
		cmd = '0;
		errors = 0;
		tests_run = 0;
		tests_failed = 0;
		repeat (10) @(negedge clk);
		reset = 1'b1;
		@(negedge clk);
		test_axis_lines();
		test_octants();
		test_zero_length();
		test_clipping();
		test_gaps_restart();
		test_random_lines();
		assert_fails = line_engine_inst.draw_line_inst.checker_inst.fail_count;
		$display("Tests run: %0d, failed: %0d, failed checks: %0d, assertion failures: %0d",
			tests_run, tests_failed, errors, assert_fails);
		if (errors == 0 && tests_failed == 0 && assert_fails == 0)
			$display("Simulation finished: PASS");
		else
			$display("Simulation finished: FAIL");
		$finish;
	end

endmodule

//--- compile.f
common/raster_pkg.sv
common/engine_pkg.sv
verilog/flex_counter.sv
draw_line/line_setup.sv
draw_line/line_stepper.sv
draw_line/draw_line.sv
verilog/screen_clip.sv
verilog/line_engine_top.sv
testbench/line_engine_checker.sv
testbench/line_engine_tb.sv

//--- Makefile
# Verilator build and run of the line engine testbench

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator, run, and check for the pass message"
	@echo "  clean  remove the Verilator build directory"

test:
	verilator --binary --timing --assert --timescale 1ns/100ps \
		--top-module line_engine_tb -Mdir obj_dir -f compile.f
	@out="$$(./obj_dir/Vline_engine_tb +verilator+error+limit+100)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Simulation finished: PASS"

clean:
	rm -rf obj_dir
